/* ex_params.svh */
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// operand word width
`define EX_WORD_W 32

// shift amount taken from the low bits of operand 1
`define EX_SHAMT_W 5

// one shift-add iteration per multiplier bit
`define EX_MUL_STEPS 32

`endif

/* ex_pkg.sv */
`include "ex_params.svh"

package ex_pkg;

    // kept operations, single-cycle ones first
    typedef enum logic [4:0] {
        OP_AND   = 5'd0,
        OP_OR    = 5'd1,
        OP_XOR   = 5'd2,
        OP_NOR   = 5'd3,
        OP_LUI   = 5'd4,
        OP_SLL   = 5'd5,
        OP_SRL   = 5'd6,
        OP_SRA   = 5'd7,
        OP_ADDU  = 5'd8,
        OP_SUBU  = 5'd9,
        OP_SLT   = 5'd10,
        OP_SLTU  = 5'd11,
        OP_MOVN  = 5'd12,
        OP_MOVZ  = 5'd13,
        OP_MFHI  = 5'd14,
        OP_MFLO  = 5'd15,
        OP_MTHI  = 5'd16,
        OP_MTLO  = 5'd17,
        OP_MULT  = 5'd18,
        OP_MULTU = 5'd19
    } ex_op_e;

    // decoded instruction as handed over by the requester
    typedef struct packed {
        ex_op_e                op;
        logic [`EX_WORD_W-1:0] reg1;
        logic [`EX_WORD_W-1:0] reg2;
        logic [4:0]            wreg_addr;
        logic                  wreg_write;
    } ex_inst_t;

    // register file write-back
    typedef struct packed {
        logic                  wreg_write;
        logic [4:0]            wreg_addr;
        logic [`EX_WORD_W-1:0] wreg_data;
    } ex_result_t;

    typedef struct packed {
        logic [`EX_WORD_W-1:0] hi;
        logic [`EX_WORD_W-1:0] lo;
    } hilo_pair_t;

    // product view for the multiplier, half view for the moves
    typedef union packed {
        logic [2*`EX_WORD_W-1:0] dword;
        hilo_pair_t              pair;
    } hilo_u;

endpackage

/* ex_ctrl.sv */
module ex_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           req_i,
    input  ex_pkg::ex_op_e op_i,
    input  logic           last_step_i,
    output logic           ack_o,
    output logic           capture_o,
    output logic           mul_start_o,
    output logic           mul_en_o,
    output logic           hilo_we_o,
    output logic           result_we_o
);

    typedef enum logic [2:0] {
        IDLE,
        EXEC,
        MUL,
        ACK,
        DROP
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   is_mul;
    logic   is_mt;

    assign is_mul = (op_i == ex_pkg::OP_MULT) || (op_i == ex_pkg::OP_MULTU);
    assign is_mt  = (op_i == ex_pkg::OP_MTHI) || (op_i == ex_pkg::OP_MTLO);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        capture_o   = 1'b0;
        mul_start_o = 1'b0;
        mul_en_o    = 1'b0;
        hilo_we_o   = 1'b0;
        result_we_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    capture_o = 1'b1;
                    state_d   = EXEC;
                end
            end
            EXEC: begin
                // captured operands are stable here, so the multiplier loads now
                if (is_mul) begin
                    mul_start_o = 1'b1;
                    state_d     = MUL;
                end else begin
                    result_we_o = 1'b1;
                    hilo_we_o   = is_mt;
                    state_d     = ACK;
                end
            end
            MUL: begin
                if (last_step_i) begin
                    hilo_we_o   = 1'b1;
                    result_we_o = 1'b1;
                    state_d     = ACK;
                end else begin
                    mul_en_o = 1'b1;
                end
            end
            // hold ack until the requester lets go
            ACK: begin
                if (!req_i) begin
                    state_d = DROP;
                end
            end
            DROP: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign ack_o = (state_q == ACK);

endmodule

/* mul_step_counter.sv */
`include "ex_params.svh"

module mul_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    input  logic en_i,
    output logic last_step_o
);

    localparam int CNT_W = $clog2(`EX_MUL_STEPS + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             active_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q    <= '0;
            active_q <= 1'b0;
        end else if (start_i) begin
            cnt_q    <= CNT_W'(`EX_MUL_STEPS);
            active_q <= 1'b1;
        end else if (cnt_q != '0) begin
            if (en_i) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end else begin
            // done flag lasts one cycle once the count is spent
            active_q <= 1'b0;
        end
    end

    assign last_step_o = active_q && (cnt_q == '0);

endmodule

/* mul_shift_add.sv */
`include "ex_params.svh"

module mul_shift_add (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_i,
    input  logic                  en_i,
    input  logic [`EX_WORD_W-1:0] reg1_i,
    input  logic [`EX_WORD_W-1:0] reg2_i,
    input  logic                  signed_i,
    output ex_pkg::hilo_u         product_o
);

    logic [`EX_WORD_W-1:0]   abs_reg1;
    logic [`EX_WORD_W-1:0]   abs_reg2;
    logic [`EX_WORD_W-1:0]   mcand_q;
    logic [2*`EX_WORD_W-1:0] prod_q;
    logic [`EX_WORD_W:0]     upper_sum;
    logic                    neg_q;

    // magnitudes for MULT, raw operands for MULTU
    assign abs_reg1 = (signed_i && reg1_i[`EX_WORD_W-1]) ? -reg1_i : reg1_i;
    assign abs_reg2 = (signed_i && reg2_i[`EX_WORD_W-1]) ? -reg2_i : reg2_i;

    // upper half plus multiplicand when the current multiplier bit is set
    assign upper_sum = {1'b0, prod_q[2*`EX_WORD_W-1:`EX_WORD_W]}
                     + (prod_q[0] ? {1'b0, mcand_q} : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_q <= '0;
            neg_q  <= 1'b0;
        end else if (start_i) begin
            // multiplier sits in the low half and shifts out one bit per step
            prod_q <= {{`EX_WORD_W{1'b0}}, abs_reg2};
            neg_q  <= signed_i && (reg1_i[`EX_WORD_W-1] ^ reg2_i[`EX_WORD_W-1]);
        end else if (en_i) begin
            prod_q <= {upper_sum, prod_q[`EX_WORD_W-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q <= abs_reg1;
        end
    end

    // sign fix-up on the accumulated magnitude
    assign product_o.dword = neg_q ? -prod_q : prod_q;

endmodule

/* ex_alu.sv */
`include "ex_params.svh"

module ex_alu (
    input  ex_pkg::ex_inst_t   inst_i,
    input  ex_pkg::hilo_u      hilo_i,
    output ex_pkg::ex_result_t result_o,
    output ex_pkg::hilo_u      hilo_next_o
);

    logic [`EX_WORD_W-1:0]  reg1;
    logic [`EX_WORD_W-1:0]  reg2;
    logic [`EX_WORD_W-1:0]  sum;
    logic [`EX_WORD_W-1:0]  diff;
    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   signed_lt;
    logic                   unsigned_lt;

    assign reg1  = inst_i.reg1;
    assign reg2  = inst_i.reg2;
    assign shamt = reg1[`EX_SHAMT_W-1:0];

    assign sum  = reg1 + reg2;
    assign diff = reg1 - reg2;

    // differing signs decide directly, otherwise the difference sign does
    assign signed_lt   = (reg1[`EX_WORD_W-1] != reg2[`EX_WORD_W-1]) ?
                         reg1[`EX_WORD_W-1] : diff[`EX_WORD_W-1];
    assign unsigned_lt = (reg1 < reg2);

    always_comb begin
        result_o.wreg_write = inst_i.wreg_write;
        result_o.wreg_addr  = inst_i.wreg_addr;
        result_o.wreg_data  = '0;
        hilo_next_o         = hilo_i;
        case (inst_i.op)
            ex_pkg::OP_AND:  result_o.wreg_data = reg1 & reg2;
            ex_pkg::OP_OR:   result_o.wreg_data = reg1 | reg2;
            ex_pkg::OP_XOR:  result_o.wreg_data = reg1 ^ reg2;
            ex_pkg::OP_NOR:  result_o.wreg_data = ~(reg1 | reg2);
            ex_pkg::OP_LUI:  result_o.wreg_data = {reg2[`EX_WORD_W/2-1:0], {(`EX_WORD_W/2){1'b0}}};
            ex_pkg::OP_SLL:  result_o.wreg_data = reg2 << shamt;
            ex_pkg::OP_SRL:  result_o.wreg_data = reg2 >> shamt;
            ex_pkg::OP_SRA:  result_o.wreg_data = $signed(reg2) >>> shamt;
            ex_pkg::OP_ADDU: result_o.wreg_data = sum;
            ex_pkg::OP_SUBU: result_o.wreg_data = diff;
            ex_pkg::OP_SLT:  result_o.wreg_data = {{(`EX_WORD_W-1){1'b0}}, signed_lt};
            ex_pkg::OP_SLTU: result_o.wreg_data = {{(`EX_WORD_W-1){1'b0}}, unsigned_lt};
            ex_pkg::OP_MOVN: begin
                if (reg2 != '0) begin
                    result_o.wreg_data = reg1;
                end else begin
                    result_o.wreg_write = 1'b0;
                end
            end
            ex_pkg::OP_MOVZ: begin
                if (reg2 == '0) begin
                    result_o.wreg_data = reg1;
                end else begin
                    result_o.wreg_write = 1'b0;
                end
            end
            ex_pkg::OP_MFHI: result_o.wreg_data = hilo_i.pair.hi;
            ex_pkg::OP_MFLO: result_o.wreg_data = hilo_i.pair.lo;
            // moves replace one half and keep the other
            ex_pkg::OP_MTHI: begin
                result_o.wreg_write = 1'b0;
                hilo_next_o.pair.hi = reg1;
            end
            ex_pkg::OP_MTLO: begin
                result_o.wreg_write = 1'b0;
                hilo_next_o.pair.lo = reg1;
            end
            // product goes to HI/LO only
            ex_pkg::OP_MULT, ex_pkg::OP_MULTU: result_o.wreg_write = 1'b0;
            default: begin
            end
        endcase
    end

endmodule

/* hilo_regs.sv */
module hilo_regs (
    input  logic          clk,
    input  logic          rst,
    input  logic          we_i,
    input  logic          from_mul_i,
    input  ex_pkg::hilo_u mul_i,
    input  ex_pkg::hilo_u alu_i,
    output ex_pkg::hilo_u hilo_o
);

    ex_pkg::hilo_u hilo_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            hilo_q.dword <= '0;
        end else if (we_i) begin
            if (from_mul_i) begin
                // full 64-bit product
                hilo_q.dword <= mul_i.dword;
            end else begin
                // move result, one half already replaced by the ALU
                hilo_q.pair.hi <= alu_i.pair.hi;
                hilo_q.pair.lo <= alu_i.pair.lo;
            end
        end
    end

    // read path straight from the registers
    assign hilo_o = hilo_q;

endmodule

/* ex_unit.sv */
module ex_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_i,
    input  ex_pkg::ex_inst_t   inst_i,
    output logic               ack_o,
    output ex_pkg::ex_result_t result_o,
    output ex_pkg::hilo_u      hilo_o
);

    ex_pkg::ex_inst_t   inst_q;
    ex_pkg::ex_result_t alu_result;
    ex_pkg::ex_result_t result_q;
    ex_pkg::hilo_u      alu_hilo;
    ex_pkg::hilo_u      mul_product;

    logic capture;
    logic mul_start;
    logic mul_en;
    logic hilo_we;
    logic result_we;
    logic last_step;
    logic is_mul_op;
    logic is_signed_mul;

    // one captured instruction feeds both the ALU and the multiplier
    always_ff @(posedge clk) begin
        if (capture) begin
            inst_q <= inst_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_q.wreg_write <= 1'b0;
        end else if (result_we) begin
            result_q <= alu_result;
        end
    end

    assign result_o = result_q;

    assign is_mul_op     = (inst_q.op == ex_pkg::OP_MULT) || (inst_q.op == ex_pkg::OP_MULTU);
    assign is_signed_mul = (inst_q.op == ex_pkg::OP_MULT);

    ex_ctrl u_ex_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .op_i        (inst_q.op),
        .last_step_i (last_step),
        .ack_o       (ack_o),
        .capture_o   (capture),
        .mul_start_o (mul_start),
        .mul_en_o    (mul_en),
        .hilo_we_o   (hilo_we),
        .result_we_o (result_we)
    );

    mul_step_counter u_mul_step_counter (
        .clk         (clk),
        .rst         (rst),
        .start_i     (mul_start),
        .en_i        (mul_en),
        .last_step_o (last_step)
    );

    mul_shift_add u_mul_shift_add (
        .clk       (clk),
        .rst       (rst),
        .start_i   (mul_start),
        .en_i      (mul_en),
        .reg1_i    (inst_q.reg1),
        .reg2_i    (inst_q.reg2),
        .signed_i  (is_signed_mul),
        .product_o (mul_product)
    );

    ex_alu u_ex_alu (
        .inst_i      (inst_q),
        .hilo_i      (hilo_o),
        .result_o    (alu_result),
        .hilo_next_o (alu_hilo)
    );

    hilo_regs u_hilo_regs (
        .clk        (clk),
        .rst        (rst),
        .we_i       (hilo_we),
        .from_mul_i (is_mul_op),
        .mul_i      (mul_product),
        .alu_i      (alu_hilo),
        .hilo_o     (hilo_o)
    );

endmodule

/* ex_unit_assertions.sv */
`include "ex_params.svh"

module ex_unit_assertions (
    input logic               clk,
    input logic               rst,
    input logic               req_i,
    input ex_pkg::ex_inst_t   inst_i,
    input logic               ack_i,
    input ex_pkg::ex_result_t result_i,
    input ex_pkg::hilo_u      hilo_i,
    input logic               capture_i
);

    ex_pkg::ex_inst_t        inst_s;
    ex_pkg::hilo_u           ref_q;
    ex_pkg::hilo_u           exp_hilo;
    logic [`EX_WORD_W-1:0]   exp_data;
    logic                    exp_write;
    logic [2*`EX_WORD_W-1:0] sext1;
    logic [2*`EX_WORD_W-1:0] sext2;
    logic [2*`EX_WORD_W-1:0] zext1;
    logic [2*`EX_WORD_W-1:0] zext2;
    logic [2*`EX_WORD_W-1:0] sra_wide;
    logic                    ack_q;
    logic                    ack_rise;
    int                      err_count = 0;

    // shadow of the instruction the unit is working on
    always_ff @(posedge clk) begin
        if (capture_i) begin
            inst_s <= inst_i;
        end
    end

    assign ack_rise = ack_i && !ack_q;

    // reference HI/LO follows each finished instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q       <= 1'b0;
            ref_q.dword <= '0;
        end else begin
            ack_q <= ack_i;
            if (ack_rise) begin
                ref_q <= exp_hilo;
            end
        end
    end

    always_comb begin
        exp_hilo  = ref_q;
        exp_data  = '0;
        exp_write = inst_s.wreg_write;
        sext1     = {{`EX_WORD_W{inst_s.reg1[`EX_WORD_W-1]}}, inst_s.reg1};
        sext2     = {{`EX_WORD_W{inst_s.reg2[`EX_WORD_W-1]}}, inst_s.reg2};
        zext1     = {{`EX_WORD_W{1'b0}}, inst_s.reg1};
        zext2     = {{`EX_WORD_W{1'b0}}, inst_s.reg2};
        // arithmetic shift as a logical shift of the sign-extended word
        sra_wide  = sext2 >> inst_s.reg1[`EX_SHAMT_W-1:0];
        case (inst_s.op)
            ex_pkg::OP_AND:  exp_data = inst_s.reg1 & inst_s.reg2;
            ex_pkg::OP_OR:   exp_data = inst_s.reg1 | inst_s.reg2;
            ex_pkg::OP_XOR:  exp_data = inst_s.reg1 ^ inst_s.reg2;
            ex_pkg::OP_NOR:  exp_data = ~(inst_s.reg1 | inst_s.reg2);
            ex_pkg::OP_LUI:  exp_data = {inst_s.reg2[15:0], 16'h0000};
            ex_pkg::OP_SLL:  exp_data = inst_s.reg2 << inst_s.reg1[`EX_SHAMT_W-1:0];
            ex_pkg::OP_SRL:  exp_data = inst_s.reg2 >> inst_s.reg1[`EX_SHAMT_W-1:0];
            ex_pkg::OP_SRA:  exp_data = sra_wide[`EX_WORD_W-1:0];
            ex_pkg::OP_ADDU: exp_data = inst_s.reg1 + inst_s.reg2;
            ex_pkg::OP_SUBU: exp_data = inst_s.reg1 - inst_s.reg2;
            ex_pkg::OP_SLT:  exp_data = ($signed(inst_s.reg1) < $signed(inst_s.reg2)) ? 1 : 0;
            ex_pkg::OP_SLTU: exp_data = (inst_s.reg1 < inst_s.reg2) ? 1 : 0;
            ex_pkg::OP_MOVN: begin
                exp_data  = inst_s.reg1;
                exp_write = inst_s.wreg_write && (inst_s.reg2 != 0);
            end
            ex_pkg::OP_MOVZ: begin
                exp_data  = inst_s.reg1;
                exp_write = inst_s.wreg_write && (inst_s.reg2 == 0);
            end
            ex_pkg::OP_MFHI: exp_data = ref_q.pair.hi;
            ex_pkg::OP_MFLO: exp_data = ref_q.pair.lo;
            ex_pkg::OP_MTHI: begin
                exp_write         = 1'b0;
                exp_hilo.pair.hi  = inst_s.reg1;
            end
            ex_pkg::OP_MTLO: begin
                exp_write         = 1'b0;
                exp_hilo.pair.lo  = inst_s.reg1;
            end
            // low 64 bits of the sign-extended product give the signed result
            ex_pkg::OP_MULT: begin
                exp_write      = 1'b0;
                exp_hilo.dword = sext1 * sext2;
            end
            ex_pkg::OP_MULTU: begin
                exp_write      = 1'b0;
                exp_hilo.dword = zext1 * zext2;
            end
            default: begin
            end
        endcase
    end

    a_write_flag: assert property (@(posedge clk) disable iff (rst)
        ack_rise |-> result_i.wreg_write == exp_write)
        else begin
            $error("write flag differs from expected");
            err_count++;
        end

    a_write_data: assert property (@(posedge clk) disable iff (rst)
        ack_rise && exp_write |->
            result_i.wreg_data == exp_data && result_i.wreg_addr == inst_s.wreg_addr)
        else begin
            $error("write-back data or address differs from expected");
            err_count++;
        end

    a_hilo_update: assert property (@(posedge clk) disable iff (rst)
        ack_rise |-> hilo_i.dword == exp_hilo.dword)
        else begin
            $error("HI/LO differs from expected after acknowledge");
            err_count++;
        end

    a_hilo_hold: assert property (@(posedge clk) disable iff (rst)
        !ack_rise |-> hilo_i.dword == ref_q.dword)
        else begin
            $error("HI/LO changed outside an acknowledge");
            err_count++;
        end

    a_result_stable: assert property (@(posedge clk) disable iff (rst)
        ack_i && ack_q |-> $stable(result_i))
        else begin
            $error("result changed while acknowledged");
            err_count++;
        end

    // req seen at the edge that raised ack
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        ack_rise |-> $past(req_i))
        else begin
            $error("ack rose without a request");
            err_count++;
        end

    a_ack_held: assert property (@(posedge clk) disable iff (rst)
        ack_i && req_i |=> ack_i)
        else begin
            $error("ack fell while request still high");
            err_count++;
        end

    a_reset_values: assert property (@(posedge clk) disable iff (rst)
        $fell(rst) |-> !ack_i && !result_i.wreg_write && hilo_i.dword == '0)
        else begin
            $error("unit not in reset state after reset");
            err_count++;
        end

endmodule

bind ex_unit ex_unit_assertions u_ex_unit_assertions (
    .clk       (clk),
    .rst       (rst),
    .req_i     (req_i),
    .inst_i    (inst_i),
    .ack_i     (ack_o),
    .result_i  (result_o),
    .hilo_i    (hilo_o),
    .capture_i (capture)
);

/* tb_ex_unit.sv */
`include "ex_params.svh"

module tb_ex_unit;

    localparam int ALU_REPS    = 4;
    localparam int MUL_REPS    = 3;
    // alu sweep, move tests, multiply rounds, edge products and HI/LO moves
    localparam int NUM_OPS     = 12 * ALU_REPS + 4 + 6 * MUL_REPS + 6;
    localparam int CYCLE_LIMIT = 60 * NUM_OPS;

    logic               clk;
    logic               rst;
    logic               req_i;
    ex_pkg::ex_inst_t   inst_i;
    logic               ack_o;
    ex_pkg::ex_result_t result_o;
    ex_pkg::hilo_u      hilo_o;
    int                 cycle_count = 0;

    ex_unit u_ex_unit (
        .clk      (clk),
        .rst      (rst),
        .req_i    (req_i),
        .inst_i   (inst_i),
        .ack_o    (ack_o),
        .result_o (result_o),
        .hilo_o   (hilo_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // waits until ack matches level, checking just after each edge
    task automatic wait_ack_level(input logic level);
        @(posedge clk);
        #2;
        while (ack_o != level) begin
            @(posedge clk);
            #2;
        end
    endtask

    // one full four-phase transfer
    task automatic issue_op(
        input ex_pkg::ex_op_e        op,
        input logic [`EX_WORD_W-1:0] r1,
        input logic [`EX_WORD_W-1:0] r2
    );
        ex_pkg::ex_inst_t inst;
        int unsigned      hold_cycles;
        inst.op         = op;
        inst.reg1       = r1;
        inst.reg2       = r2;
        inst.wreg_addr  = 5'($urandom);
        inst.wreg_write = 1'b1;
        inst_i = inst;
        req_i  = 1'b1;
        wait_ack_level(1'b1);
        // back-pressure keeps req high for a few more cycles
        hold_cycles = $urandom_range(2, 0);
        repeat (hold_cycles) begin
            @(posedge clk);
            #2;
        end
        req_i  = 1'b0;
        wait_ack_level(1'b0);
    endtask

    // assertion failures are counted inside the bound checker
    always @(negedge clk) begin
        if (u_ex_unit.u_ex_unit_assertions.err_count != 0) begin
            $display("Mismatch at time %0t: assertion failed", $time);
            $display("TESTS FAILED");
            $fatal(1, "stopping on first assertion failure");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: unit never acknowledged");
            $display("TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        void'($urandom(32'hbc61));
        rst      = 1'b1;
        req_i    = 1'b0;
        inst_i   = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;

        // every single-cycle op from AND to SLTU on random operands
        for (int rep = 0; rep < ALU_REPS; rep++) begin
            for (int k = 0; k <= 11; k++) begin
                issue_op(ex_pkg::ex_op_e'(k), $urandom, $urandom);
            end
        end

        // both outcomes of each zero test
        issue_op(ex_pkg::OP_MOVN, $urandom, 32'h0);
        issue_op(ex_pkg::OP_MOVN, $urandom, $urandom | 32'h1);
        issue_op(ex_pkg::OP_MOVZ, $urandom, 32'h0);
        issue_op(ex_pkg::OP_MOVZ, $urandom, $urandom | 32'h1);

        for (int rep = 0; rep < MUL_REPS; rep++) begin
            issue_op(ex_pkg::OP_MULT, $urandom, $urandom);
            issue_op(ex_pkg::OP_MFHI, $urandom, $urandom);
            issue_op(ex_pkg::OP_MFLO, $urandom, $urandom);
            issue_op(ex_pkg::OP_MULTU, $urandom, $urandom);
            issue_op(ex_pkg::OP_MFHI, $urandom, $urandom);
            issue_op(ex_pkg::OP_MFLO, $urandom, $urandom);
        end

        // most negative times minus one, largest unsigned squared, small negative
        issue_op(ex_pkg::OP_MULT, 32'h8000_0000, 32'hffff_ffff);
        issue_op(ex_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        issue_op(ex_pkg::OP_MULT, 32'hffff_fffb, 32'h0000_0007);

        issue_op(ex_pkg::OP_MTHI, $urandom, $urandom);
        issue_op(ex_pkg::OP_MTLO, $urandom, $urandom);
        issue_op(ex_pkg::OP_MFHI, $urandom, $urandom);

        // let the last checks settle
        repeat (2) @(posedge clk);
        #2;
        if (u_ex_unit.u_ex_unit_assertions.err_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Mismatch at time %0t: assertion failed", $time);
            $display("TESTS FAILED");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

/* tb.f */
+incdir+.
ex_pkg.sv
ex_ctrl.sv
mul_step_counter.sv
mul_shift_add.sv
ex_alu.sv
hilo_regs.sv
ex_unit.sv
ex_unit_assertions.sv
tb_ex_unit.sv
